//--- sim.f
rtl/tcdm_pkg.sv
rtl/amo_pkg.sv
rtl/bank_if.sv
rtl/amo_alu.sv
rtl/lrsc_monitor.sv
rtl/tcdm_adapter.sv
rtl/sram_bank.sv
rtl/tcdm_bank_top.sv
tests/tcdm_adapter_asserts.sv
tests/tb_tcdm_bank.sv

//--- run.sh
#!/bin/sh
# Build the TCDM bank testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_tcdm_bank -o tb_tcdm_bank
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_tcdm_bank > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
  exit 0
fi
exit 1

//--- tests/tb_tcdm_bank.sv
/* TCDM bank testbench, directed and random requests checked in order
   against a shadow memory with its own AMO and LR/SC model */

`timescale 1ns/1ps
`default_nettype none

module tb_tcdm_bank import tcdm_pkg::*, amo_pkg::*; ();

  localparam int unsigned NumWords  = 256;
  localparam int unsigned WordBits  = $clog2(NumWords);
  localparam int          ClkPeriod = 100;
  localparam int          StimDelay = 10;
  localparam int          NumRandom = 200;
  // Init, AMO sweep of 9 ops x 3 x 3 corners x 3 requests, directed extras, random
  localparam int          NumRequests = NumWords + 9 * 9 * 3 + 32 + NumRandom;
  localparam int          WatchdogCycles = NumRequests * 40 * 2;

  logic     clk_i, rst_ni;
  logic     in_valid_i, in_ready_o, in_write_i;
  addr_t    in_addr_i;
  amo_op_e  in_amo_i;
  data_t    in_wdata_i;
  be_t      in_be_i;
  meta_t    in_meta_i;
  logic     resp_valid_o, resp_ready_i;
  data_t    resp_rdata_o;
  meta_t    resp_meta_o;

  integer      seed = 32'hc153_e92c;
  logic        bp_mode = 1'b0;
  logic [31:0] ready_rnd;
  logic [TagWidth-1:0] tag_q = '0;
  int          issue_count = 0;
  int          resp_count = 0;
  data_t       corner_val [3] = '{32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff};

  // Reference model state
  data_t                shadow [NumWords];
  logic                 res_valid = 1'b0;
  logic [WordBits-1:0]  res_addr = '0;
  core_id_t             res_core = '0;
  data_t                exp_data_q [$];
  meta_t                exp_meta_q [$];
  bit                   exp_chk_q [$];

  tcdm_bank_top #(
    .NumWords    (NumWords),
    .RegisterAmo (1'b1),
    .LrScEnable  (1'b1)
  ) dut (
    .clk_i, .rst_ni, .in_valid_i, .in_ready_o, .in_addr_i, .in_amo_i, .in_write_i,
    .in_wdata_i, .in_be_i, .in_meta_i, .resp_valid_o, .resp_ready_i, .resp_rdata_o,
    .resp_meta_o
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // ------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------
  function automatic data_t merge_bytes(input data_t old, input data_t nw, input be_t be);
    data_t res;
    res = old;
    for (int i = 0; i < BeWidth; i++) begin
      if (be[i]) res[8*i +: 8] = nw[8*i +: 8];
    end
    return res;
  endfunction

  function automatic data_t amo_ref(input amo_op_e op, input data_t old, input data_t opnd);
    case (op)
      AmoSwap: return opnd;
      AmoAdd:  return old + opnd;
      AmoAnd:  return old & opnd;
      AmoOr:   return old | opnd;
      AmoXor:  return old ^ opnd;
      AmoMax:  return ($signed(old) >= $signed(opnd)) ? old : opnd;
      AmoMaxu: return (old >= opnd) ? old : opnd;
      AmoMin:  return ($signed(old) <= $signed(opnd)) ? old : opnd;
      AmoMinu: return (old <= opnd) ? old : opnd;
      default: return old;
    endcase
  endfunction

  // Applies one accepted request to the shadow memory and reservation
  function automatic void predict(input amo_op_e op, input logic write, input addr_t addr,
                                  input data_t wdata, input be_t be, input meta_t meta,
                                  output data_t exp_data, output meta_t exp_meta,
                                  output bit exp_chk);
    logic [WordBits-1:0] widx;
    data_t               old;
    logic                owner;
    logic                modifies;
    widx     = addr[2 +: WordBits];
    old      = shadow[widx];
    owner    = res_valid && (res_core == meta.core_id);
    modifies = 1'b0;
    exp_data = old;
    exp_meta = meta;
    exp_chk  = 1'b1;
    if (op == AmoNone) begin
      // Store data field carries nothing useful
      if (write) begin
        shadow[widx] = merge_bytes(old, wdata, be);
        exp_chk      = 1'b0;
        modifies     = 1'b1;
      end
    end else if (op == AmoLr) begin
      if (!res_valid || res_core == meta.core_id) begin
        res_valid = 1'b1;
        res_addr  = widx;
        res_core  = meta.core_id;
      end
    end else if (op == AmoSc) begin
      exp_data = (owner && res_addr == widx) ? 32'd0 : 32'd1;
      if (owner && res_addr == widx) shadow[widx] = merge_bytes(old, wdata, be);
      if (owner) res_valid = 1'b0;
    end else begin
      shadow[widx] = merge_bytes(old, amo_ref(op, old, wdata), be);
      modifies     = 1'b1;
    end
    // Foreign write to the reserved word breaks the reservation
    if (modifies && meta.core_id != res_core && widx == res_addr) res_valid = 1'b0;
  endfunction

  // Distinct per-word content, every address bit shows up
  function automatic data_t fill_word(input int idx);
    logic [7:0] w;
    w = idx[7:0];
    return {w ^ 8'h3c, w, ~w, w + 8'h11};
  endfunction

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_data(input data_t got, input data_t exp, input meta_t meta);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0t ns: core %0d tag %0d data %h, expected %h",
                          $time, meta.core_id, meta.tag, got, exp));
    end
  endtask

  task automatic check_meta(input meta_t got, input meta_t exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0t ns: metadata %h, expected %h", $time, got, exp));
    end
  endtask

  // Response taken at the next edge, sampled mid-cycle
  always @(negedge clk_i) begin : compare_resp
    meta_t exp_meta;
    data_t exp_data;
    bit    exp_chk;
    if (rst_ni && resp_valid_o && resp_ready_i) begin
      if (exp_meta_q.size() == 0) begin
        abort_run($sformatf("response at %0t ns with no request outstanding", $time));
      end else begin
        exp_meta = exp_meta_q.pop_front();
        exp_data = exp_data_q.pop_front();
        exp_chk  = exp_chk_q.pop_front();
        check_meta(resp_meta_o, exp_meta);
        if (exp_chk) check_data(resp_rdata_o, exp_data, exp_meta);
        resp_count++;
      end
    end
  end

  initial begin : watchdog
    #(WatchdogCycles * ClkPeriod);
    abort_run($sformatf("timeout, test did not finish within %0d cycles", WatchdogCycles));
  end

  // Random stalls on the response side in back-pressure mode
  initial begin : drive_resp_ready
    resp_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      ready_rnd = $random(seed);
      if (!bp_mode) ready_rnd[0] = 1'b1;
      #StimDelay;
      resp_ready_i = ready_rnd[0];
    end
  end

  // ------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------
  // Called just after a stimulus point, returns at the next one
  task automatic issue(input amo_op_e op, input logic write, input addr_t addr,
                       input data_t wdata, input be_t be, input core_id_t core);
    meta_t meta;
    data_t exp_data;
    meta_t exp_meta;
    bit    exp_chk;
    meta.core_id = core;
    meta.tag     = tag_q;
    in_valid_i   = 1'b1;
    in_amo_i     = op;
    in_write_i   = write;
    in_addr_i    = addr;
    in_wdata_i   = wdata;
    in_be_i      = be;
    in_meta_i    = meta;
    while (!in_ready_o) begin
      @(posedge clk_i);
      #StimDelay;
    end
    // Handshake happens at the coming edge
    predict(op, write, addr, wdata, be, meta, exp_data, exp_meta, exp_chk);
    exp_data_q.push_back(exp_data);
    exp_meta_q.push_back(exp_meta);
    exp_chk_q.push_back(exp_chk);
    @(posedge clk_i);
    #StimDelay;
    in_valid_i = 1'b0;
    tag_q++;
    issue_count++;
  endtask

  task automatic store(input addr_t addr, input data_t data, input be_t be,
                       input core_id_t core);
    issue(AmoNone, 1'b1, addr, data, be, core);
  endtask

  task automatic load(input addr_t addr, input core_id_t core);
    issue(AmoNone, 1'b0, addr, '0, 4'hf, core);
  endtask

  initial begin : main
    logic [31:0] rnd;
    int          op_sel;
    in_valid_i = 1'b0;
    in_addr_i  = '0;
    in_amo_i   = AmoNone;
    in_write_i = 1'b0;
    in_wdata_i = '0;
    in_be_i    = '0;
    in_meta_i  = '0;
    rst_ni     = 1'b0;
    repeat (8) @(posedge clk_i);
    #StimDelay;
    rst_ni = 1'b1;

    // Bank contents are not reset, fill every word first
    for (int i = 0; i < NumWords; i++) begin
      store(addr_t'(i << 2), fill_word(i), 4'hf, 4'd0);
    end

    // Partial byte-enable stores merge into the word
    store(32'h40, 32'hdead_beef, 4'b0001, 4'd0);
    store(32'h40, 32'h1234_5678, 4'b0110, 4'd1);
    load(32'h40, 4'd2);
    store(32'h44, 32'ha5a5_a5a5, 4'b1000, 4'd3);
    store(32'h44, 32'h0f0f_0f0f, 4'b0001, 4'd3);
    load(32'h44, 4'd1);

    // Every AMO over the signed and unsigned corner values
    for (int o = 1; o <= 9; o++) begin
      for (int a = 0; a < 3; a++) begin
        for (int b = 0; b < 3; b++) begin
          store(32'h80, corner_val[a], 4'hf, 4'd5);
          issue(amo_op_e'(o[3:0]), 1'b0, 32'h80, corner_val[b], 4'hf, 4'd5);
          load(32'h80, 4'd6);
        end
      end
    end

    // LR/SC success, broken reservation, and SC with no reservation
    issue(AmoLr, 1'b0, 32'h100, '0, 4'hf, 4'd1);
    issue(AmoSc, 1'b0, 32'h100, 32'h1234_5678, 4'hf, 4'd1);
    load(32'h100, 4'd1);
    issue(AmoLr, 1'b0, 32'h104, '0, 4'hf, 4'd2);
    store(32'h104, 32'hcafe_f00d, 4'hf, 4'd3);
    issue(AmoSc, 1'b0, 32'h104, 32'h1111_1111, 4'hf, 4'd2);
    load(32'h104, 4'd2);
    issue(AmoSc, 1'b0, 32'h108, 32'h2222_2222, 4'hf, 4'd4);
    load(32'h108, 4'd4);

    // Random mix on eight shared words under back-pressure
    bp_mode = 1'b1;
    for (int n = 0; n < NumRandom; n++) begin
      rnd    = $random(seed);
      op_sel = int'(rnd[7:0]) % 12;
      if (op_sel == 0) begin
        issue(AmoNone, rnd[20], 32'h200 | {27'h0, rnd[10:8], 2'b00}, $random(seed),
              rnd[19:16], {2'b00, rnd[13:12]});
      end else begin
        issue(amo_op_e'(op_sel[3:0]), 1'b0, 32'h200 | {27'h0, rnd[10:8], 2'b00},
              $random(seed), 4'hf, {2'b00, rnd[13:12]});
      end
    end
    bp_mode = 1'b0;

    // Drain, then make sure nothing else shows up
    while (exp_meta_q.size() != 0) @(posedge clk_i);
    repeat (4) @(posedge clk_i);
    #StimDelay;
    if (!resp_valid_o && in_ready_o) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      abort_run($sformatf("DUT not idle after %0d requests and %0d responses",
                          issue_count, resp_count));
    end
  end

endmodule

`default_nettype wire

//--- tests/tcdm_adapter_asserts.sv
/* Response handshake, AMO blocking and FIFO overflow checks for the adapter */

`timescale 1ns/1ps
`default_nettype none

module tcdm_adapter_asserts import tcdm_pkg::*, amo_pkg::*; (
  input logic    clk_i,
  input logic    rst_ni,
  input logic    in_valid_i,
  input amo_op_e in_amo_i,
  input logic    in_ready_o,
  input logic    resp_valid_o,
  input logic    resp_ready_i,
  input data_t   resp_rdata_o,
  input meta_t   resp_meta_o,
  input logic    register_amo_i,
  input logic    rdata_push_i,
  input logic    rdata_full_i
);

  // A stalled response keeps valid, data and metadata until taken
  property resp_held_p;
    @(posedge clk_i) disable iff (!rst_ni)
      resp_valid_o && !resp_ready_i |=>
        resp_valid_o && $stable(resp_rdata_o) && $stable(resp_meta_o);
  endproperty
  assert property (resp_held_p) else $error("response changed while stalled");

  // An accepted AMO holds off requests for DoAmo, and for WriteBackAmo when registered
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_valid_i && in_ready_o && !(in_amo_i inside {AmoNone, AmoLr, AmoSc}) |=>
      !in_ready_o ##1 (!register_amo_i || !in_ready_o))
    else $error("request accepted during AMO write-back");

  // Two entries are the most that can wait
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rdata_push_i |-> !rdata_full_i)
    else $error("read data pushed into a full FIFO");

endmodule

bind tcdm_adapter tcdm_adapter_asserts i_adapter_asserts (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .in_valid_i     (in_valid_i),
  .in_amo_i       (in_amo_i),
  .in_ready_o     (in_ready_o),
  .resp_valid_o   (resp_valid_o),
  .resp_ready_i   (resp_ready_i),
  .resp_rdata_o   (resp_rdata_o),
  .resp_meta_o    (resp_meta_o),
  .register_amo_i (RegisterAmo),
  .rdata_push_i   (rdata_push),
  .rdata_full_i   (rdata_full)
);

`default_nettype wire

//--- rtl/tcdm_bank_top.sv
/* One TCDM bank, the request adapter in front of its SRAM */

`timescale 1ns/1ps
`default_nettype none

module tcdm_bank_top import tcdm_pkg::*, amo_pkg::*; #(
  parameter int unsigned NumWords    = 256,
  parameter bit          RegisterAmo = 1'b0,
  parameter bit          LrScEnable  = 1'b1
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  // Request side
  input  logic    in_valid_i,
  output logic    in_ready_o,
  input  addr_t   in_addr_i,
  input  amo_op_e in_amo_i,
  input  logic    in_write_i,
  input  data_t   in_wdata_i,
  input  be_t     in_be_i,
  input  meta_t   in_meta_i,
  // Response side
  output logic    resp_valid_o,
  input  logic    resp_ready_i,
  output data_t   resp_rdata_o,
  output meta_t   resp_meta_o
);

  // Adapter to bank link
  bank_if #(.NumWords(NumWords)) bank ();

  tcdm_adapter #(
    .NumWords    (NumWords),
    .RegisterAmo (RegisterAmo),
    .LrScEnable  (LrScEnable)
  ) i_tcdm_adapter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .in_addr_i    (in_addr_i),
    .in_amo_i     (in_amo_i),
    .in_write_i   (in_write_i),
    .in_wdata_i   (in_wdata_i),
    .in_be_i      (in_be_i),
    .in_meta_i    (in_meta_i),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_rdata_o (resp_rdata_o),
    .resp_meta_o  (resp_meta_o),
    .bank         (bank.master)
  );

  sram_bank #(
    .NumWords (NumWords)
  ) i_sram_bank (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bank   (bank.slave)
  );

endmodule

`default_nettype wire

//--- rtl/sram_bank.sv
/* Single-port SRAM bank, byte write enables and registered read */

`timescale 1ns/1ps
`default_nettype none

module sram_bank import tcdm_pkg::*; #(
  parameter int unsigned NumWords = 256
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  bank_if.slave  bank
);

  // Storage as bytes per word
  logic [BeWidth-1:0][7:0] mem_q [NumWords];

  // Byte lanes written only where enabled
  always_ff @(posedge clk_i) begin
    if (bank.req && bank.write) begin
      for (int unsigned i = 0; i < BeWidth; i++) begin
        if (bank.be[i]) mem_q[bank.addr][i] <= bank.wdata[8*i +: 8];
      end
    end
  end

  // Read first, a write returns the old word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bank.rdata <= '0;
    end else if (bank.req) begin
      bank.rdata <= mem_q[bank.addr];
    end
  end

endmodule

`default_nettype wire

//--- rtl/tcdm_adapter.sv
/* Valid/ready to SRAM adapter with in-order metadata return,
   response buffering, AMO read-modify-write and LR/SC */

`timescale 1ns/1ps
`default_nettype none

module tcdm_adapter import tcdm_pkg::*, amo_pkg::*; #(
  parameter int unsigned NumWords    = 256,
  // Register the ALU result before write-back, one more blocking cycle
  parameter bit          RegisterAmo = 1'b0,
  parameter bit          LrScEnable  = 1'b1
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  // Request side
  input  logic    in_valid_i,
  output logic    in_ready_o,
  input  addr_t   in_addr_i,
  input  amo_op_e in_amo_i,
  input  logic    in_write_i,
  input  data_t   in_wdata_i,
  input  be_t     in_be_i,
  input  meta_t   in_meta_i,
  // Response side
  output logic    resp_valid_o,
  input  logic    resp_ready_i,
  output data_t   resp_rdata_o,
  output meta_t   resp_meta_o,
  // SRAM bank
  bank_if.master  bank
);

  localparam int unsigned OffsetWidth   = $clog2(BeWidth);
  localparam int unsigned WordAddrWidth = $clog2(NumWords);

  logic                     accept, is_amo, pop_resp;
  logic [WordAddrWidth-1:0] word_addr;
  adapter_state_e           state_q, state_d;
  logic                     load_amo, amo_wb;
  amo_op_e                  amo_op_q;
  logic [WordAddrWidth-1:0] amo_addr_q;
  be_t                      amo_be_q;
  data_t                    amo_operand_q, amo_result, amo_result_q;
  logic                     sc_success, sc_success_q, sc_q;
  // Bank read data returns this cycle
  logic                     gnt_q;
  data_t                    resp_data;

  assign accept    = in_valid_i && in_ready_o;
  // Drop the byte offset
  assign word_addr = in_addr_i[OffsetWidth +: WordAddrWidth];
  assign is_amo    = !(in_amo_i inside {AmoNone, AmoLr, AmoSc});

  // ------------------------------------------------------------------
  // Response data FIFO, two entries, fall-through when empty
  // ------------------------------------------------------------------
  data_t      rdata_mem [2];
  logic [1:0] rdata_count_q;
  logic       rdata_wptr_q, rdata_rptr_q;
  logic       rdata_push, rdata_store, rdata_unload;
  logic       rdata_empty, rdata_full, rdata_valid;

  assign rdata_push   = gnt_q;
  assign rdata_empty  = (rdata_count_q == 2'd0);
  assign rdata_full   = (rdata_count_q == 2'd2);
  assign rdata_valid  = !rdata_empty || rdata_push;
  // A push that leaves in the same cycle is never stored
  assign rdata_store  = rdata_push && !(rdata_empty && pop_resp);
  assign rdata_unload = pop_resp && !rdata_empty;
  assign resp_rdata_o = rdata_empty ? resp_data : rdata_mem[rdata_rptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_count_q <= 2'd0;
      rdata_wptr_q  <= 1'b0;
      rdata_rptr_q  <= 1'b0;
    end else begin
      rdata_count_q <= rdata_count_q + {1'b0, rdata_store} - {1'b0, rdata_unload};
      if (rdata_store) rdata_wptr_q <= !rdata_wptr_q;
      if (rdata_unload) rdata_rptr_q <= !rdata_rptr_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rdata_store) rdata_mem[rdata_wptr_q] <= resp_data;
  end

  // ------------------------------------------------------------------
  // Metadata spill buffer, slot 0 is the head
  // ------------------------------------------------------------------
  meta_t meta0_q, meta1_q, meta0_d, meta1_d;
  logic  meta0_valid_q, meta1_valid_q, meta0_valid_d, meta1_valid_d;

  always_comb begin
    meta0_d       = meta0_q;
    meta1_d       = meta1_q;
    meta0_valid_d = meta0_valid_q;
    meta1_valid_d = meta1_valid_q;
    // Shift up on a pop
    if (pop_resp) begin
      meta0_d       = meta1_q;
      meta0_valid_d = meta1_valid_q;
      meta1_valid_d = 1'b0;
    end
    // New entry goes to the first free slot
    if (accept) begin
      if (!meta0_valid_d) begin
        meta0_d       = in_meta_i;
        meta0_valid_d = 1'b1;
      end else begin
        meta1_d       = in_meta_i;
        meta1_valid_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      meta0_valid_q <= 1'b0;
      meta1_valid_q <= 1'b0;
    end else begin
      meta0_valid_q <= meta0_valid_d;
      meta1_valid_q <= meta1_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    meta0_q <= meta0_d;
    meta1_q <= meta1_d;
  end

  // Read data always arrives after its metadata
  assign resp_valid_o = meta0_valid_q && rdata_valid;
  assign resp_meta_o  = meta0_q;
  assign pop_resp     = resp_valid_o && resp_ready_i;

  // Only take a request with nothing waiting in the FIFO
  assign in_ready_o = (state_q == Idle) && rdata_empty;

  // ------------------------------------------------------------------
  // LR/SC
  // ------------------------------------------------------------------
  if (LrScEnable) begin : gen_lrsc
    lrsc_monitor #(
      .NumWords (NumWords)
    ) i_lrsc_monitor (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .accept_i     (accept),
      .op_i         (in_amo_i),
      .write_i      (in_write_i),
      .word_addr_i  (word_addr),
      .core_i       (in_meta_i.core_id),
      .sc_success_o (sc_success)
    );
  end else begin : gen_no_lrsc
    // Every SC fails
    assign sc_success = 1'b0;
  end

  // SC response is 0 on success, 1 on failure
  assign resp_data = sc_q ? {{(DataWidth-1){1'b0}}, !sc_success_q} : bank.rdata;

  // ------------------------------------------------------------------
  // Bank access and AMO sequencing
  // ------------------------------------------------------------------
  always_comb begin
    bank.req   = accept;
    bank.addr  = word_addr;
    bank.wdata = in_wdata_i;
    bank.be    = in_be_i;
    // LR and AMOs only read here, SC writes on success
    unique case (in_amo_i)
      AmoNone: bank.write = in_write_i;
      AmoSc:   bank.write = sc_success;
      default: bank.write = 1'b0;
    endcase
    state_d  = state_q;
    load_amo = 1'b0;
    amo_wb   = 1'b0;
    unique case (state_q)
      Idle: begin
        if (accept && is_amo) begin
          load_amo = 1'b1;
          state_d  = DoAmo;
        end
      end
      // Old word is on rdata, either write it back now or register first
      DoAmo: begin
        state_d = RegisterAmo ? WriteBackAmo : Idle;
        amo_wb  = !RegisterAmo;
      end
      WriteBackAmo: begin
        state_d = Idle;
        amo_wb  = 1'b1;
      end
      default: state_d = Idle;
    endcase
    // Claim the bank for the write-back
    if (amo_wb) begin
      bank.req   = 1'b1;
      bank.addr  = amo_addr_q;
      bank.write = 1'b1;
      bank.wdata = RegisterAmo ? amo_result_q : amo_result;
      bank.be    = amo_be_q;
    end
  end

  amo_alu i_amo_alu (
    .op_i      (amo_op_q),
    .mem_i     (bank.rdata),
    .operand_i (amo_operand_q),
    .result_o  (amo_result)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= Idle;
      amo_op_q     <= AmoNone;
      gnt_q        <= 1'b0;
      sc_q         <= 1'b0;
      sc_success_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      if (load_amo) amo_op_q <= in_amo_i;
      // Write-backs produce no response
      gnt_q        <= bank.req && !amo_wb;
      sc_q         <= accept && (in_amo_i == AmoSc);
      sc_success_q <= sc_success;
    end
  end

  // AMO request fields and the registered result
  always_ff @(posedge clk_i) begin
    if (load_amo) begin
      amo_addr_q    <= word_addr;
      amo_be_q      <= in_be_i;
      amo_operand_q <= in_wdata_i;
    end
    if (state_q == DoAmo) amo_result_q <= amo_result;
  end

endmodule

`default_nettype wire

//--- rtl/lrsc_monitor.sv
/* Single-entry LR/SC reservation table, gives the SC verdict
   combinationally in the cycle the SC is accepted */

`timescale 1ns/1ps
`default_nettype none

module lrsc_monitor import tcdm_pkg::*, amo_pkg::*; #(
  parameter int unsigned NumWords = 256
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        accept_i,
  input  amo_op_e                     op_i,
  input  logic                        write_i,
  input  logic [$clog2(NumWords)-1:0] word_addr_i,
  input  core_id_t                    core_i,
  output logic                        sc_success_o
);

  localparam int unsigned WordAddrWidth = $clog2(NumWords);

  logic                     res_valid_q, res_valid_d;
  logic [WordAddrWidth-1:0] res_addr_q, res_addr_d;
  core_id_t                 res_core_q, res_core_d;
  logic                     is_store;
  logic                     owner;

  // Plain stores and real AMOs modify memory, LR and SC do not count
  assign is_store = (op_i == AmoNone && write_i) ||
                    !(op_i inside {AmoNone, AmoLr, AmoSc});
  assign owner    = res_valid_q && (res_core_q == core_i);

  // Owner SC to the reserved word
  assign sc_success_o = accept_i && (op_i == AmoSc) && owner && (res_addr_q == word_addr_i);

  always_comb begin
    res_valid_d = res_valid_q;
    res_addr_d  = res_addr_q;
    res_core_d  = res_core_q;
    if (accept_i) begin
      // New reservation only when free or already held by this core
      if (op_i == AmoLr && (!res_valid_q || res_core_q == core_i)) begin
        res_valid_d = 1'b1;
        res_addr_d  = word_addr_i;
        res_core_d  = core_i;
      end
      // Another core modified the reserved word
      if (is_store && core_i != res_core_q && word_addr_i == res_addr_q) begin
        res_valid_d = 1'b0;
      end
      // Any SC of the owner ends the reservation, hit or miss
      if (op_i == AmoSc && owner) begin
        res_valid_d = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q <= 1'b0;
      res_addr_q  <= '0;
      res_core_q  <= '0;
    end else begin
      res_valid_q <= res_valid_d;
      res_addr_q  <= res_addr_d;
      res_core_q  <= res_core_d;
    end
  end

endmodule

`default_nettype wire

//--- rtl/amo_alu.sv
/* AMO arithmetic, combines the old memory word with the operand
   for the nine RISC-V read-modify-write operations */

`timescale 1ns/1ps
`default_nettype none

module amo_alu import tcdm_pkg::*, amo_pkg::*; (
  input  amo_op_e op_i,
  input  data_t   mem_i,
  input  data_t   operand_i,
  output data_t   result_o
);

  // One extra bit so that the borrow gives the compare result
  logic [DataWidth:0] cmp_lhs;
  logic [DataWidth:0] cmp_rhs;
  logic [DataWidth:0] cmp_diff;
  logic               signed_cmp;
  logic               mem_lt;

  // Sign-extend for max/min, zero-extend for the unsigned pair
  assign signed_cmp = (op_i == AmoMax) || (op_i == AmoMin);
  assign cmp_lhs    = {signed_cmp & mem_i[DataWidth-1], mem_i};
  assign cmp_rhs    = {signed_cmp & operand_i[DataWidth-1], operand_i};
  assign cmp_diff   = cmp_lhs - cmp_rhs;

  // Negative difference means the memory word is the smaller one
  assign mem_lt = cmp_diff[DataWidth];

  always_comb begin
    unique case (op_i)
      AmoSwap: result_o = operand_i;
      AmoAdd:  result_o = mem_i + operand_i;
      AmoAnd:  result_o = mem_i & operand_i;
      AmoOr:   result_o = mem_i | operand_i;
      AmoXor:  result_o = mem_i ^ operand_i;
      // Keep the larger value
      AmoMax,
      AmoMaxu: result_o = mem_lt ? operand_i : mem_i;
      // Keep the smaller value
      AmoMin,
      AmoMinu: result_o = mem_lt ? mem_i : operand_i;
      // LR, SC, plain accesses and unused codes
      default: result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/bank_if.sv
/* Adapter to SRAM bank link, single port with one cycle read latency */

`timescale 1ns/1ps
`default_nettype none

interface bank_if import tcdm_pkg::*; #(
  parameter int unsigned NumWords = 256
) ();

  localparam int unsigned WordAddrWidth = $clog2(NumWords);

  // Request, always taken by the bank
  logic                     req;
  // Word index, not a byte address
  logic [WordAddrWidth-1:0] addr;
  logic                     write;
  data_t                    wdata;
  be_t                      be;
  // Valid in the cycle after an accepted req
  data_t                    rdata;

  modport master (
    output req, addr, write, wdata, be,
    input  rdata
  );

  modport slave (
    input  req, addr, write, wdata, be,
    output rdata
  );

endinterface

`default_nettype wire

//--- rtl/amo_pkg.sv
/* Atomic opcode encodings and the adapter's AMO sequencing states */

`default_nettype none

package amo_pkg;

  // Opcode carried on the request, matches the interconnect encoding
  typedef enum logic [3:0] {
    AmoNone = 4'h0,
    AmoSwap = 4'h1,
    AmoAdd  = 4'h2,
    AmoAnd  = 4'h3,
    AmoOr   = 4'h4,
    AmoXor  = 4'h5,
    AmoMax  = 4'h6,
    AmoMaxu = 4'h7,
    AmoMin  = 4'h8,
    AmoMinu = 4'h9,
    AmoLr   = 4'hA,
    AmoSc   = 4'hB
  } amo_op_e;

  // Read phase happens in Idle, write-back in DoAmo or WriteBackAmo
  typedef enum logic [1:0] {
    Idle,
    DoAmo,
    WriteBackAmo
  } adapter_state_e;

endpackage

`default_nettype wire

//--- rtl/tcdm_pkg.sv
/* TCDM bus geometry and the request metadata returned with every response */

`default_nettype none

package tcdm_pkg;

  // ------------------------------------------------------------------
  // Word and address geometry
  // ------------------------------------------------------------------
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned BeWidth     = DataWidth / 8;
  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned CoreIdWidth = 4;
  localparam int unsigned TagWidth    = 4;

  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [BeWidth-1:0]     be_t;
  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [CoreIdWidth-1:0] core_id_t;

  // Issuing core and its transaction tag
  // Travels with the request and comes back on the response
  typedef struct packed {
    core_id_t            core_id;
    logic [TagWidth-1:0] tag;
  } meta_t;

endpackage

`default_nettype wire
